// File: src/tile_consts.svh
`ifndef TILE_CONSTS_SVH
`define TILE_CONSTS_SVH

// ----------------------------------------------------------------------
// Tile sizing
// ----------------------------------------------------------------------
`define TILE_REG_NUM  8
`define TILE_DATA_W   16
`define TILE_ROB_SIZE 4

// ----------------------------------------------------------------------
// Opcode field values, instruction bits 15 to 13
// ----------------------------------------------------------------------
`define TILE_OP_ADD 3'd0
`define TILE_OP_SUB 3'd1
`define TILE_OP_AND 3'd2
`define TILE_OP_XOR 3'd3
// Load 8-bit immediate, zero extended
`define TILE_OP_LI  3'd4

`endif

// File: src/tile_pkg.sv
`default_nettype none

package tile_pkg;

`include "tile_consts.svh"

  localparam int REG_IDX_W = $clog2(`TILE_REG_NUM);
  localparam int CMT_ID_W  = $clog2(`TILE_ROB_SIZE);
  localparam int IMM_W     = 8;

  typedef logic [15:0]             inst_t;
  typedef logic [REG_IDX_W-1:0]    reg_idx_t;
  typedef logic [`TILE_DATA_W-1:0] data_t;
  typedef logic [CMT_ID_W-1:0]     cmt_id_t;
  typedef logic [IMM_W-1:0]        imm_t;

  typedef enum logic [2:0] {
    ALU_ADD = `TILE_OP_ADD,
    ALU_SUB = `TILE_OP_SUB,
    ALU_AND = `TILE_OP_AND,
    ALU_XOR = `TILE_OP_XOR,
    ALU_LI  = `TILE_OP_LI
  } alu_op_e;

  // Dispatched instruction, decoder to ALU and ROB
  typedef struct packed {
    logic     valid;
    alu_op_e  op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    imm_t     imm;
    cmt_id_t  cmt_id;
  } disp_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    data_t    data;
  } phy_wr_t;

  typedef struct packed {
    logic    valid;
    cmt_id_t cmt_id;
    data_t   data;
  } done_rpt_t;

  typedef struct packed {
    logic     valid;
    cmt_id_t  cmt_id;
    reg_idx_t rd;
    data_t    data;
  } commit_t;

endpackage

`default_nettype wire

// File: src/tile_disp_decode.sv
`default_nettype none

`include "tile_consts.svh"

module tile_disp_decode (
  input  logic               i_clk,
  input  logic               i_arst_n,

  input  logic               i_inst_valid,
  input  tile_pkg::inst_t    i_inst,
  output logic               o_inst_ready,

  input  logic               i_rob_free,
  input  tile_pkg::cmt_id_t  i_rob_new_id,
  input  tile_pkg::phy_wr_t  i_phy_wr,

  output tile_pkg::disp_t    o_disp
);

  tile_pkg::reg_idx_t        w_rd;
  tile_pkg::reg_idx_t        w_rs1;
  tile_pkg::reg_idx_t        w_rs2;
  tile_pkg::imm_t            w_imm;
  logic [2:0]                w_opcode;
  tile_pkg::alu_op_e         w_op;
  logic                      w_reads_src;

  logic [`TILE_REG_NUM-1:0]  r_busy;
  logic [`TILE_REG_NUM-1:0]  w_wb_clr;
  logic [`TILE_REG_NUM-1:0]  w_busy;
  logic [`TILE_REG_NUM-1:0]  w_set;
  logic                      w_src_busy;
  logic                      w_accept;
  logic                      r_run;

  logic                      r_disp_valid;
  tile_pkg::disp_t           r_disp;

  // ----------------------------------------------------------------------
  // Instruction split
  // ----------------------------------------------------------------------
  assign w_opcode = i_inst[15:13];
  assign w_rd     = i_inst[12:10];
  assign w_rs1    = i_inst[9:7];
  assign w_rs2    = i_inst[6:4];
  assign w_imm    = i_inst[7:0];

  always_comb begin
    w_reads_src = 1'b1;
    case (w_opcode)
      `TILE_OP_ADD: w_op = tile_pkg::ALU_ADD;
      `TILE_OP_SUB: w_op = tile_pkg::ALU_SUB;
      `TILE_OP_AND: w_op = tile_pkg::ALU_AND;
      `TILE_OP_XOR: w_op = tile_pkg::ALU_XOR;
      `TILE_OP_LI: begin
        w_op        = tile_pkg::ALU_LI;
        w_reads_src = 1'b0;
      end
      default: w_op = tile_pkg::alu_op_e'(w_opcode);
    endcase
  end

  // ----------------------------------------------------------------------
  // Scoreboard
  // ----------------------------------------------------------------------
  // A writeback frees its register, unless a younger writer of the same
  // register sits in the dispatch stage right now
  always_comb begin
    for (int i = 0; i < `TILE_REG_NUM; i++) begin
      w_wb_clr[i] = i_phy_wr.valid && (i_phy_wr.rd == tile_pkg::reg_idx_t'(i)) &&
                    !(r_disp_valid && (r_disp.rd == tile_pkg::reg_idx_t'(i)));
    end
  end

  assign w_busy     = r_busy & ~w_wb_clr;
  assign w_src_busy = w_reads_src && (w_busy[w_rs1] || w_busy[w_rs2]);

  assign o_inst_ready = r_run && i_rob_free && !w_src_busy;
  assign w_accept     = i_inst_valid && o_inst_ready;

  // Register 0 never becomes busy
  always_comb begin
    w_set = '0;
    if (w_accept && (w_rd != '0)) begin
      w_set[w_rd] = 1'b1;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_busy       <= '0;
      r_run        <= 1'b0;
      r_disp_valid <= 1'b0;
    end else begin
      r_busy       <= w_busy | w_set;
      r_run        <= 1'b1;
      r_disp_valid <= w_accept;
    end
  end

  // Dispatch payload
  always_ff @(posedge i_clk) begin
    if (w_accept) begin
      r_disp <= '{valid:  1'b1,
                  op:     w_op,
                  rd:     w_rd,
                  rs1:    w_rs1,
                  rs2:    w_rs2,
                  imm:    w_imm,
                  cmt_id: i_rob_new_id};
    end
  end

  always_comb begin
    o_disp       = r_disp;
    o_disp.valid = r_disp_valid;
  end

  // Fetch source only offers the five defined opcodes
  a_disp_op_known : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_disp.valid |-> o_disp.op inside {tile_pkg::ALU_ADD, tile_pkg::ALU_SUB,
                                       tile_pkg::ALU_AND, tile_pkg::ALU_XOR,
                                       tile_pkg::ALU_LI});

endmodule

`default_nettype wire

// File: src/tile_phy_registers.sv
`default_nettype none

`include "tile_consts.svh"

module tile_phy_registers (
  input  logic               i_clk,
  input  logic               i_arst_n,

  input  tile_pkg::reg_idx_t i_rs1,
  input  tile_pkg::reg_idx_t i_rs2,
  output tile_pkg::data_t    o_rs1_data,
  output tile_pkg::data_t    o_rs2_data,

  input  tile_pkg::phy_wr_t  i_phy_wr
);

  tile_pkg::data_t r_regs [`TILE_REG_NUM];

  // Single write port, register 0 stays zero
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < `TILE_REG_NUM; i++) begin
        r_regs[i] <= '0;
      end
    end else if (i_phy_wr.valid && (i_phy_wr.rd != '0)) begin
      r_regs[i_phy_wr.rd] <= i_phy_wr.data;
    end
  end

  // Asynchronous reads, no write bypass
  assign o_rs1_data = r_regs[i_rs1];
  assign o_rs2_data = r_regs[i_rs2];

endmodule

`default_nettype wire

// File: src/tile_alu.sv
`default_nettype none

module tile_alu (
  input  logic                i_clk,
  input  logic                i_arst_n,

  input  tile_pkg::disp_t     i_disp,

  output tile_pkg::reg_idx_t  o_rs1,
  output tile_pkg::reg_idx_t  o_rs2,
  input  tile_pkg::data_t     i_rs1_data,
  input  tile_pkg::data_t     i_rs2_data,

  output tile_pkg::phy_wr_t   o_phy_wr,
  output tile_pkg::done_rpt_t o_done_rpt
);

  tile_pkg::data_t    w_result;

  logic               r_valid;
  tile_pkg::reg_idx_t r_rd;
  tile_pkg::cmt_id_t  r_cmt_id;
  tile_pkg::data_t    r_data;

  // Register read in the dispatch cycle
  assign o_rs1 = i_disp.rs1;
  assign o_rs2 = i_disp.rs2;

  always_comb begin
    case (i_disp.op)
      tile_pkg::ALU_ADD: w_result = i_rs1_data + i_rs2_data;
      tile_pkg::ALU_SUB: w_result = i_rs1_data - i_rs2_data;
      tile_pkg::ALU_AND: w_result = i_rs1_data & i_rs2_data;
      tile_pkg::ALU_XOR: w_result = i_rs1_data ^ i_rs2_data;
      tile_pkg::ALU_LI:  w_result = tile_pkg::data_t'(i_disp.imm);
      default:           w_result = '0;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= i_disp.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_disp.valid) begin
      r_rd     <= i_disp.rd;
      r_cmt_id <= i_disp.cmt_id;
      r_data   <= w_result;
    end
  end

  // Writeback and done report leave together
  assign o_phy_wr   = '{valid: r_valid, rd: r_rd, data: r_data};
  assign o_done_rpt = '{valid: r_valid, cmt_id: r_cmt_id, data: r_data};

  // Source operands come from written registers
  a_src_known : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_disp.valid && (i_disp.op != tile_pkg::ALU_LI)) |->
      !$isunknown({i_rs1_data, i_rs2_data}));

endmodule

`default_nettype wire

// File: src/tile_rob.sv
`default_nettype none

`include "tile_consts.svh"

module tile_rob (
  input  logic                i_clk,
  input  logic                i_arst_n,

  input  tile_pkg::disp_t     i_disp,
  output logic                o_rob_free,
  output tile_pkg::cmt_id_t   o_new_id,

  input  tile_pkg::done_rpt_t i_done_rpt,

  output tile_pkg::commit_t   o_commit
);

  localparam int CNT_W = $clog2(`TILE_ROB_SIZE + 1);

  tile_pkg::cmt_id_t        r_head;
  tile_pkg::cmt_id_t        r_tail;
  logic [CNT_W-1:0]         r_count;
  logic [CNT_W-1:0]         w_count_next;
  logic [`TILE_ROB_SIZE-1:0] r_done;

  tile_pkg::reg_idx_t       r_rd   [`TILE_ROB_SIZE];
  tile_pkg::data_t          r_data [`TILE_ROB_SIZE];

  logic                     w_cmt_fire;
  tile_pkg::cmt_id_t        w_done_age;

  // ----------------------------------------------------------------------
  // Occupancy
  // ----------------------------------------------------------------------
  assign w_cmt_fire   = (r_count != '0) && r_done[r_head];
  assign w_count_next = r_count + CNT_W'(i_disp.valid) - CNT_W'(w_cmt_fire);

  // Free check already accounts for the entry in flight from the decoder
  assign o_rob_free = w_count_next < CNT_W'(`TILE_ROB_SIZE);
  assign o_new_id   = r_tail + tile_pkg::cmt_id_t'(i_disp.valid);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_head  <= '0;
      r_tail  <= '0;
      r_count <= '0;
      r_done  <= '0;
    end else begin
      r_count <= w_count_next;
      if (w_cmt_fire) begin
        r_done[r_head] <= 1'b0;
        r_head         <= r_head + 1'b1;
      end
      if (i_done_rpt.valid) begin
        r_done[i_done_rpt.cmt_id] <= 1'b1;
      end
      // Allocation last so a full buffer may reuse the retiring slot
      if (i_disp.valid) begin
        r_done[r_tail] <= 1'b0;
        r_tail         <= r_tail + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Entry payload
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_disp.valid) begin
      r_rd[r_tail] <= i_disp.rd;
    end
    if (i_done_rpt.valid) begin
      r_data[i_done_rpt.cmt_id] <= i_done_rpt.data;
    end
  end

  assign o_commit = '{valid:  w_cmt_fire,
                      cmt_id: r_head,
                      rd:     r_rd[r_head],
                      data:   r_data[r_head]};

  // Distance of the reported entry from the head
  assign w_done_age = i_done_rpt.cmt_id - r_head;

  a_no_disp_when_full : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_disp.valid |-> (r_count < CNT_W'(`TILE_ROB_SIZE)));

  a_done_live_entry : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_done_rpt.valid |-> (CNT_W'(w_done_age) < r_count) && !r_done[i_done_rpt.cmt_id]);

endmodule

`default_nettype wire

// File: src/tile_top.sv
`default_nettype none

module tile_top (
  input  logic              i_clk,
  input  logic              i_arst_n,

  input  logic              i_inst_valid,
  input  tile_pkg::inst_t   i_inst,
  output logic              o_inst_ready,

  output tile_pkg::commit_t o_commit
);

  // ----------------------------------------------------------------------
  // Internal buses
  // ----------------------------------------------------------------------
  tile_pkg::disp_t     w_disp;
  tile_pkg::phy_wr_t   w_phy_wr;
  tile_pkg::done_rpt_t w_done_rpt;

  logic                w_rob_free;
  tile_pkg::cmt_id_t   w_rob_new_id;

  tile_pkg::reg_idx_t  w_rs1;
  tile_pkg::reg_idx_t  w_rs2;
  tile_pkg::data_t     w_rs1_data;
  tile_pkg::data_t     w_rs2_data;

  tile_disp_decode u_disp_decode (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .o_inst_ready (o_inst_ready),
    .i_rob_free   (w_rob_free),
    .i_rob_new_id (w_rob_new_id),
    .i_phy_wr     (w_phy_wr),
    .o_disp       (w_disp)
  );

  tile_alu u_alu (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_disp     (w_disp),
    .o_rs1      (w_rs1),
    .o_rs2      (w_rs2),
    .i_rs1_data (w_rs1_data),
    .i_rs2_data (w_rs2_data),
    .o_phy_wr   (w_phy_wr),
    .o_done_rpt (w_done_rpt)
  );

  tile_phy_registers u_phy_registers (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_rs1      (w_rs1),
    .i_rs2      (w_rs2),
    .o_rs1_data (w_rs1_data),
    .o_rs2_data (w_rs2_data),
    .i_phy_wr   (w_phy_wr)
  );

  tile_rob u_rob (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_disp     (w_disp),
    .o_rob_free (w_rob_free),
    .o_new_id   (w_rob_new_id),
    .i_done_rpt (w_done_rpt),
    .o_commit   (o_commit)
  );

endmodule

`default_nettype wire

// File: tests/tile_tb.sv
`default_nettype none

`include "tile_consts.svh"

module tile_tb;

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 16;
  localparam int DRIVE_DLY  = 2;
  localparam int GOLD_DEPTH = 128;
  localparam int MAX_GAP    = 3;
  localparam int LATENCY    = 3;
  // Worst case per word: latency, idle gap and scoreboard or ROB stall
  localparam int WORD_CYCLES = LATENCY + MAX_GAP + 4;
  localparam int MARGIN      = 64;

  logic              clk;
  logic              arst_n;
  logic              inst_valid;
  tile_pkg::inst_t   inst;
  logic              inst_ready;
  tile_pkg::commit_t commit;

  logic [31:0] gold [GOLD_DEPTH];
  logic [31:0] exp_q [$];
  int          accept_q [$];
  logic [31:0] exp_entry;
  int          acc_cycle;
  int          cycle;
  int          cycle_limit;
  int          err_cnt;
  int          test_err_cnt;
  int          commit_cnt;
  int          test_cnt;
  logic        check_latency;
  logic        mon_en;

  tile_top dut (
    .i_clk        (clk),
    .i_arst_n     (arst_n),
    .i_inst_valid (inst_valid),
    .i_inst       (inst),
    .o_inst_ready (inst_ready),
    .o_commit     (commit)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // Cycle count and run limit
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= cycle_limit) begin
      $display("Run stopped after %0d cycles, commits stopped arriving", cycle);
      $display("Errors found");
      $finish;
    end
  end

  task automatic count_error();
    err_cnt++;
    test_err_cnt++;
  endtask

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      count_error();
    end
  endtask

  // ----------------------------------------------------------------------
  // Commit monitor, sampled mid-cycle where o_commit is stable
  // ----------------------------------------------------------------------
  always @(negedge clk) begin
    if (mon_en && commit.valid) begin
      commit_cnt++;
      if (exp_q.size() == 0 || accept_q.size() == 0) begin
        $display("Commit of cmt_id %0d arrived with no word left to expect it",
                 commit.cmt_id);
        count_error();
      end else begin
        exp_entry = exp_q.pop_front();
        acc_cycle = accept_q.pop_front();
        check_value("o_commit.rd", 16'(commit.rd), 16'(exp_entry[27:24]));
        check_value("o_commit.cmt_id", 16'(commit.cmt_id), 16'(exp_entry[23:16]));
        check_value("o_commit.data", commit.data, exp_entry[15:0]);
        if (check_latency && (cycle - acc_cycle != LATENCY)) begin
          $display("Commit of cmt_id %0d came %0d cycles after acceptance, not %0d",
                   commit.cmt_id, cycle - acc_cycle, LATENCY);
          count_error();
        end
      end
    end
  end

  // Holds the word until a rising edge sees valid and ready together
  task automatic drive_word(input tile_pkg::inst_t word);
    logic accepted;
    accepted   = 1'b0;
    inst_valid = 1'b1;
    inst       = word;
    while (!accepted) begin
      @(negedge clk);
      accepted = inst_ready;
      if (accepted) begin
        accept_q.push_back(cycle);
      end
      @(posedge clk);
      #(DRIVE_DLY);
    end
    inst_valid = 1'b0;
  endtask

  task automatic wait_commits();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    #(DRIVE_DLY);
  endtask

  function automatic int count_words();
    int n;
    n = 0;
    for (int i = 0; i < GOLD_DEPTH; i++) begin
      if (gold[i][31:28] == 4'h1) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic check_reset_state();
    test_err_cnt = 0;
    check_value("o_commit.valid", 16'(commit.valid), 16'h0);
    check_value("o_inst_ready", 16'(inst_ready), 16'h1);
    test_cnt++;
    $display("Test 1 finished: reset state, %0d errors", test_err_cnt);
  endtask

  // One test runs from its marker up to the next marker or the end entry
  task automatic run_test(input int start, output int next);
    logic [31:0] words [$];
    logic        tight;
    int          idx;
    int          gap;
    tight        = gold[start][16];
    idx          = start + 1;
    test_err_cnt = 0;
    while (idx < GOLD_DEPTH && (gold[idx][31:28] == 4'h1 || gold[idx][31:28] == 4'h2)) begin
      if (gold[idx][31:28] == 4'h1) begin
        words.push_back(gold[idx]);
        if (!(gold[idx][15:13] inside {`TILE_OP_ADD, `TILE_OP_SUB, `TILE_OP_AND,
                                       `TILE_OP_XOR, `TILE_OP_LI})) begin
          $display("Golden word %h has no defined opcode", gold[idx][15:0]);
          count_error();
        end
      end else begin
        exp_q.push_back(gold[idx]);
      end
      idx++;
    end
    check_latency = tight;
    foreach (words[i]) begin
      if (!tight) begin
        gap = $urandom % (MAX_GAP + 1);
        repeat (gap) begin
          @(posedge clk);
          #(DRIVE_DLY);
        end
      end
      drive_word(words[i][15:0]);
    end
    wait_commits();
    test_cnt++;
    $display("Test %0d finished: %0d words, %0d errors", gold[start][15:0],
             words.size(), test_err_cnt);
    next = idx;
  endtask

  initial begin
    int seed_val;
    int idx;
    int n_words;
    inst_valid    = 1'b0;
    inst          = '0;
    arst_n        = 1'b0;
    mon_en        = 1'b0;
    check_latency = 1'b0;
    cycle         = 0;
    cycle_limit   = 1000;
    err_cnt       = 0;
    test_err_cnt  = 0;
    commit_cnt    = 0;
    test_cnt      = 0;
    // Seed the generator once
    seed_val = $urandom(72);
    for (int i = 0; i < GOLD_DEPTH; i++) begin
      gold[i] = '0;
    end
    $readmemh("tests/tile_golden.txt", gold);
    n_words     = count_words();
    cycle_limit = n_words * WORD_CYCLES + RST_CYCLES + MARGIN;

    repeat (RST_CYCLES) @(posedge clk);
    #(DRIVE_DLY);
    arst_n = 1'b1;
    mon_en = 1'b1;
    @(posedge clk);
    #(DRIVE_DLY);
    check_reset_state();

    idx = 0;
    while (idx < GOLD_DEPTH && gold[idx][31:28] == 4'h3) begin
      run_test(idx, idx);
    end
    // A few idle cycles catch duplicated commits
    repeat (8) @(posedge clk);

    $display("%0d tests, %0d words, %0d commits, %0d errors", test_cnt, n_words,
             commit_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/tile_golden.txt
// Kind in top digit: 3 test start (bit 16 back-to-back with latency check), 1 word, 0 end
// Each word is followed by its commit: 2, rd digit, cmt_id byte, data
30000002
1000845A 2100005A
100088C3 220100C3
10000CA0 2302011D
100030A0 2403FF97
100054A0 25000042
100078A0 26010099
10001DC0 270200B4
30000003
10008077 20030077
10000400 21000000
10006860 22010099
10002C50 2302FFBE
30000004
10008410 21030010
10000890 22000020
10000D10 23010030
10002DA0 23020010
100071A0 24030030
10005630 25000010
30010005
10008401 21010001
10008802 22020002
10008C03 23030003
10009004 24000004
10001770 2501014D
100084FF 210200FF
30010006
1000983C 2603003C
10009CE1 270000E1
10006530 21010001
10003130 2402FFFF
00000000

// File: sim.f
+incdir+src
src/tile_pkg.sv
src/tile_disp_decode.sv
src/tile_phy_registers.sv
src/tile_alu.sv
src/tile_rob.sv
src/tile_top.sv
tests/tile_tb.sv

// File: Bender.yml
package:
  name: tile

sources:
  - include_dirs:
      - src
    files:
      - src/tile_pkg.sv
      - src/tile_disp_decode.sv
      - src/tile_phy_registers.sv
      - src/tile_alu.sv
      - src/tile_rob.sv
      - src/tile_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/tile_tb.sv
